// File: dms_defines.svh
`ifndef DMS_DEFINES_SVH
`define DMS_DEFINES_SVH

// --------------------
// data path widths
// --------------------
`define DMS_XLEN 32
`define DMS_UART_W 8

// --------------------
// address fields
// --------------------
// dmem word address, bits 15:2
`define DMS_DMEM_ADDR_W 14
// mmio register index, bits 4:2
`define DMS_MMIO_ADDR_W 3
// set selects mmio, clear selects dmem
`define DMS_MMIO_SEL_BIT 31

`endif

// File: dms_pkg.sv
`default_nettype none

`include "dms_defines.svh"

package dms_pkg;

    // --------------------
    // data types
    // --------------------
    typedef logic [`DMS_XLEN-1:0] word_t;
    // one enable per byte lane
    typedef logic [`DMS_XLEN/8-1:0] byte_en_t;
    // byte position inside a word
    typedef logic [1:0] byte_off_t;

    // --------------------
    // opcodes
    // --------------------
    // funct3 of loads and stores
    typedef enum logic [2:0] {
        width_byte   = 3'd0,
        width_half   = 3'd1,
        width_word   = 3'd2,
        width_byte_u = 3'd4,
        width_half_u = 3'd5
    } mem_width_e;

    // mmio register index, addr bits 4:2
    typedef enum logic [2:0] {
        mmio_uart_ctrl = 3'd0,
        mmio_uart_rx   = 3'd1,
        mmio_cnt_reset = 3'd4,
        mmio_cycle_cnt = 3'd5,
        mmio_instr_cnt = 3'd6
    } mmio_reg_e;

endpackage

`default_nettype wire

// File: mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "dms_defines.svh"

// one word-addressed request per cycle, read data one cycle later
interface mem_req_if #(
    parameter int ADDR_W = `DMS_DMEM_ADDR_W
);

    logic              en;
    dms_pkg::byte_en_t we;
    logic [ADDR_W-1:0] addr;
    dms_pkg::word_t    wdata;
    dms_pkg::word_t    rdata;

    // address side, issues the request
    modport initiator (output en, we, addr, wdata, input rdata);

    // memory or register block
    modport target (input en, we, addr, wdata, output rdata);

    // read data tap for the load path
    modport monitor (input en, we, addr, wdata, rdata);

endinterface

`default_nettype wire

// File: store_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "dms_defines.svh"

module store_align (
    input  logic                req_en,
    input  logic                req_store,
    input  dms_pkg::word_t      addr,
    input  dms_pkg::word_t      store_data,
    input  dms_pkg::mem_width_e width,
    mem_req_if.initiator        dmem_req,
    mem_req_if.initiator        mmio_req
);

    import dms_pkg::*;

    byte_off_t offset;
    byte_en_t  base_en;
    byte_en_t  store_en;
    word_t     wdata_shifted;
    logic      is_mmio;
    logic      dmem_sel;
    logic      mmio_sel;

    assign offset  = addr[1:0];
    assign is_mmio = addr[`DMS_MMIO_SEL_BIT];

    // --------------------
    // byte enables
    // --------------------
    // lanes covered by the access at offset 0
    always_comb begin
        case (width)
            width_byte, width_byte_u: base_en = 4'b0001;
            width_half, width_half_u: base_en = 4'b0011;
            width_word:               base_en = 4'b1111;
            default:                  base_en = 4'b0000;
        endcase
    end

    // move lanes up to the byte offset, loads write nothing
    assign store_en = req_store ? byte_en_t'(base_en << offset) : '0;

    // store data lands on the same lanes
    assign wdata_shifted = store_data << {offset, 3'b000};

    // --------------------
    // region routing
    // --------------------
    assign dmem_sel = req_en && !is_mmio;
    assign mmio_sel = req_en && is_mmio;

    assign dmem_req.en    = dmem_sel;
    assign dmem_req.we    = dmem_sel ? store_en : '0;
    assign dmem_req.addr  = addr[`DMS_DMEM_ADDR_W+1:2];
    assign dmem_req.wdata = wdata_shifted;

    // only the register index reaches the mmio block
    assign mmio_req.en    = mmio_sel;
    assign mmio_req.we    = mmio_sel ? store_en : '0;
    assign mmio_req.addr  = addr[`DMS_MMIO_ADDR_W+1:2];
    assign mmio_req.wdata = wdata_shifted;

endmodule

`default_nettype wire

// File: dmem.sv
`timescale 1ns/1ps
`default_nettype none

`include "dms_defines.svh"

module dmem (
    input  logic      clk,
    input  logic      rst,
    mem_req_if.target mem
);

    import dms_pkg::*;

    localparam int DEPTH = 2 ** `DMS_DMEM_ADDR_W;

    word_t mem_array [DEPTH];

    // --------------------
    // write port
    // --------------------
    // per-lane write at the request edge
    always_ff @(posedge clk) begin
        if (mem.en) begin
            for (int i = 0; i < $bits(byte_en_t); i++) begin
                if (mem.we[i]) begin
                    mem_array[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
        end
    end

    // --------------------
    // read port
    // --------------------
    // old word on a same-cycle write, held between requests
    always_ff @(posedge clk) begin
        if (rst) begin
            mem.rdata <= '0;
        end else if (mem.en) begin
            mem.rdata <= mem_array[mem.addr];
        end
    end

endmodule

`default_nettype wire

// File: mmio_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "dms_defines.svh"

module mmio_regs (
    input  logic                   clk,
    input  logic                   rst,
    mem_req_if.target              mmio,
    input  logic                   req_load,
    input  logic                   req_store,
    input  logic [`DMS_UART_W-1:0] uart_rx_data,
    input  logic                   uart_rx_valid,
    input  logic                   uart_tx_ready,
    input  dms_pkg::word_t         cycle_cnt,
    input  dms_pkg::word_t         instr_cnt,
    output logic [`DMS_UART_W-1:0] uart_tx_data,
    output logic                   cnt_reset,
    output logic                   store_to_uart,
    output logic                   load_from_uart
);

    import dms_pkg::*;

    mmio_reg_e reg_idx;
    logic      wr_byte0;
    logic      rd_en;

    assign reg_idx  = mmio_reg_e'(mmio.addr);
    // registers live in byte 0 only
    assign wr_byte0 = mmio.en && mmio.we[0];
    assign rd_en    = mmio.en && req_load;

    // --------------------
    // uart strobes
    // --------------------
    // same cycle as the request, for the uart fifos
    assign store_to_uart  = wr_byte0 && req_store && (reg_idx == mmio_uart_ctrl);
    assign load_from_uart = rd_en && (reg_idx == mmio_uart_rx);

    // --------------------
    // register writes
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            uart_tx_data <= '0;
            cnt_reset    <= 1'b0;
        end else if (wr_byte0) begin
            case (reg_idx)
                mmio_uart_ctrl: uart_tx_data <= mmio.wdata[`DMS_UART_W-1:0];
                mmio_cnt_reset: cnt_reset    <= mmio.wdata[0];
                default:        ;
            endcase
        end
    end

    // --------------------
    // register reads
    // --------------------
    // sampled at the request edge, valid the next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mmio.rdata <= '0;
        end else if (rd_en) begin
            case (reg_idx)
                // status: bit 1 rx valid, bit 0 tx ready
                mmio_uart_ctrl: mmio.rdata <= word_t'({uart_rx_valid, uart_tx_ready});
                mmio_uart_rx:   mmio.rdata <= word_t'(uart_rx_data);
                mmio_cycle_cnt: mmio.rdata <= cycle_cnt;
                mmio_instr_cnt: mmio.rdata <= instr_cnt;
                default:        mmio.rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: load_shift_mask.sv
`timescale 1ns/1ps
`default_nettype none

`include "dms_defines.svh"

module load_shift_mask (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_en,
    input  logic                req_load,
    input  dms_pkg::word_t      addr,
    input  dms_pkg::mem_width_e width,
    mem_req_if.monitor          dmem_rd,
    mem_req_if.monitor          mmio_rd,
    output dms_pkg::word_t      load_data,
    output logic                load_valid
);

    import dms_pkg::*;

    logic       load_q;
    mem_width_e width_q;
    byte_off_t  offset_q;
    logic       mmio_q;
    word_t      rd_sel;
    word_t      rd_shifted;
    logic       load_acc;

    assign load_acc = req_en && req_load;

    // --------------------
    // memory-stage register
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            load_q <= 1'b0;
        end else begin
            load_q <= load_acc;
        end
    end

    // fields of the load in flight
    always_ff @(posedge clk) begin
        if (load_acc) begin
            width_q  <= width;
            offset_q <= addr[1:0];
            mmio_q   <= addr[`DMS_MMIO_SEL_BIT];
        end
    end

    // --------------------
    // shift, mask, extend
    // --------------------
    assign rd_sel     = mmio_q ? mmio_rd.rdata : dmem_rd.rdata;
    // addressed byte down to lane 0
    assign rd_shifted = rd_sel >> {offset_q, 3'b000};

    always_comb begin
        case (width_q)
            width_byte:   load_data = {{(`DMS_XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
            width_half:   load_data = {{(`DMS_XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
            width_byte_u: load_data = word_t'(rd_shifted[7:0]);
            width_half_u: load_data = word_t'(rd_shifted[15:0]);
            default:      load_data = rd_shifted;
        endcase
    end

    assign load_valid = load_q;

endmodule

`default_nettype wire

// File: data_mem_space.sv
`timescale 1ns/1ps
`default_nettype none

`include "dms_defines.svh"

module data_mem_space (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_en,
    input  logic                   req_load,
    input  logic                   req_store,
    input  dms_pkg::word_t         addr,
    input  dms_pkg::word_t         store_data,
    input  dms_pkg::mem_width_e    width,
    input  logic [`DMS_UART_W-1:0] uart_rx_data,
    input  logic                   uart_rx_valid,
    input  logic                   uart_tx_ready,
    input  dms_pkg::word_t         cycle_cnt,
    input  dms_pkg::word_t         instr_cnt,
    output dms_pkg::word_t         load_data,
    output logic                   load_valid,
    output logic                   store_to_uart,
    output logic                   load_from_uart,
    output logic [`DMS_UART_W-1:0] uart_tx_data,
    output logic                   cnt_reset
);

    import dms_pkg::*;

    // --------------------
    // request channels
    // --------------------
    mem_req_if #(.ADDR_W(`DMS_DMEM_ADDR_W)) dmem_req ();
    mem_req_if #(.ADDR_W(`DMS_MMIO_ADDR_W)) mmio_req ();

    // execute stage side
    store_align u_store_align (
        .req_en     (req_en),
        .req_store  (req_store),
        .addr       (addr),
        .store_data (store_data),
        .width      (width),
        .dmem_req   (dmem_req.initiator),
        .mmio_req   (mmio_req.initiator)
    );

    dmem u_dmem (
        .clk (clk),
        .rst (rst),
        .mem (dmem_req.target)
    );

    mmio_regs u_mmio_regs (
        .clk            (clk),
        .rst            (rst),
        .mmio           (mmio_req.target),
        .req_load       (req_load),
        .req_store      (req_store),
        .uart_rx_data   (uart_rx_data),
        .uart_rx_valid  (uart_rx_valid),
        .uart_tx_ready  (uart_tx_ready),
        .cycle_cnt      (cycle_cnt),
        .instr_cnt      (instr_cnt),
        .uart_tx_data   (uart_tx_data),
        .cnt_reset      (cnt_reset),
        .store_to_uart  (store_to_uart),
        .load_from_uart (load_from_uart)
    );

    // memory stage side
    load_shift_mask u_load_shift_mask (
        .clk        (clk),
        .rst        (rst),
        .req_en     (req_en),
        .req_load   (req_load),
        .addr       (addr),
        .width      (width),
        .dmem_rd    (dmem_req.monitor),
        .mmio_rd    (mmio_req.monitor),
        .load_data  (load_data),
        .load_valid (load_valid)
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free-running clock and power-on reset for the testbench
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for 10 rising edges, released like any other input
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #0.5;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: data_mem_space_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "dms_defines.svh"

module data_mem_space_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   req_en,
    input logic                   req_load,
    input logic                   req_store,
    input dms_pkg::word_t         addr,
    input dms_pkg::word_t         store_data,
    input logic                   load_valid,
    input logic                   store_to_uart,
    input logic                   load_from_uart,
    input logic [`DMS_UART_W-1:0] uart_tx_data,
    input logic                   cnt_reset
);

    import dms_pkg::*;

    int   fail_count = 0;
    logic load_acc;

    assign load_acc = req_en && req_load;

    // --------------------
    // reset state
    // --------------------
    reset_quiet: assert property (@(posedge clk)
        rst |=> (!load_valid && !cnt_reset && uart_tx_data == '0))
        else begin
            $error("outputs not cleared by reset");
            fail_count++;
        end

    reset_no_strobe: assert property (@(posedge clk)
        rst |-> (!store_to_uart && !load_from_uart))
        else begin
            $error("uart strobe during reset");
            fail_count++;
        end

    // --------------------
    // load latency
    // --------------------
    // valid exactly one cycle after each load
    load_one_cycle: assert property (@(posedge clk) disable iff (rst)
        load_acc |=> load_valid)
        else begin
            $error("load_valid missing one cycle after a load");
            fail_count++;
        end

    no_spurious_valid: assert property (@(posedge clk) disable iff (rst)
        !load_acc |=> !load_valid)
        else begin
            $error("load_valid without a load one cycle earlier");
            fail_count++;
        end

    // --------------------
    // uart strobes
    // --------------------
    tx_strobe_src: assert property (@(posedge clk) disable iff (rst)
        store_to_uart |-> (req_en && req_store && addr[`DMS_MMIO_SEL_BIT]
                           && addr[4:2] == 3'd0))
        else begin
            $error("store_to_uart without a store to mmio index 0");
            fail_count++;
        end

    // tx byte follows the strobe by one cycle
    tx_data_update: assert property (@(posedge clk) disable iff (rst)
        store_to_uart |=> (uart_tx_data == $past(store_data[`DMS_UART_W-1:0])))
        else begin
            $error("uart_tx_data not taken from the strobed store");
            fail_count++;
        end

    rx_strobe_src: assert property (@(posedge clk) disable iff (rst)
        load_from_uart |-> (req_en && req_load && addr[`DMS_MMIO_SEL_BIT]
                            && addr[4:2] == 3'd1))
        else begin
            $error("load_from_uart without a load from mmio index 1");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: data_mem_space_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dms_defines.svh"

module data_mem_space_tb;

    import dms_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic                   clk;
    logic                   rst;
    logic                   req_en;
    logic                   req_load;
    logic                   req_store;
    word_t                  addr;
    word_t                  store_data;
    mem_width_e             width;
    logic [`DMS_UART_W-1:0] uart_rx_data;
    logic                   uart_rx_valid;
    logic                   uart_tx_ready;
    word_t                  cycle_cnt;
    word_t                  instr_cnt;
    word_t                  load_data;
    logic                   load_valid;
    logic                   store_to_uart;
    logic                   load_from_uart;
    logic [`DMS_UART_W-1:0] uart_tx_data;
    logic                   cnt_reset;

    // side inputs applied together with the next request
    logic [7:0] rx_stage;
    logic       rx_valid_stage;
    logic       tx_ready_stage;
    word_t      cyc_stage;
    word_t      ins_stage;

    // shadow model of dmem bytes 0x00..0xff and the mmio outputs
    logic [7:0] shadow [256];
    logic       pend_valid;
    word_t      pend_data;
    logic [7:0] tx_model;
    logic       cnt_model;

    int    test_errors;
    int    passed;
    int    failed;
    int    cycles = 0;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    data_mem_space uut (.*);

    bind data_mem_space data_mem_space_chk u_chk (.*);

    // --------------------
    // reference model
    // --------------------
    function automatic int access_bytes(input mem_width_e w);
        case (w)
            width_byte, width_byte_u: return 1;
            width_half, width_half_u: return 2;
            default:                  return 4;
        endcase
    endfunction

    // field at the offset then sign or zero fill
    function automatic word_t dmem_expect(input word_t a, input mem_width_e w);
        word_t v;
        v = '0;
        for (int i = 0; i < access_bytes(w); i++) begin
            v[8*i +: 8] = shadow[int'(a[7:0]) + i];
        end
        if (w == width_byte && v[7]) begin
            v[31:8] = '1;
        end
        if (w == width_half && v[15]) begin
            v[31:16] = '1;
        end
        return v;
    endfunction

    function automatic word_t mmio_expect(input logic [2:0] idx);
        case (idx)
            3'd0:    return {30'b0, uart_rx_valid, uart_tx_ready};
            3'd1:    return word_t'(uart_rx_data);
            3'd5:    return cycle_cnt;
            3'd6:    return instr_cnt;
            default: return '0;
        endcase
    endfunction

    task automatic store_model(input word_t a, input word_t d, input mem_width_e w);
        for (int i = 0; i < access_bytes(w); i++) begin
            shadow[int'(a[7:0]) + i] = d[8*i +: 8];
        end
    endtask

    task automatic value_error(input string what, input word_t got, input word_t exp);
        $display("Error at %.1f ns: %s is %h, expected %h", $realtime, what, got, exp);
        test_errors++;
    endtask

    // --------------------
    // one request cycle
    // --------------------
    // drive after the edge and check every output at the falling edge
    task automatic issue(input logic en, input logic ld, input logic st, input word_t a,
                         input word_t d, input mem_width_e w);
        logic  exp_stu;
        logic  exp_lfu;
        word_t exp_load;
        @(posedge clk);
        #0.5;
        req_en        = en;
        req_load      = ld;
        req_store     = st;
        addr          = a;
        store_data    = d;
        width         = w;
        uart_rx_data  = rx_stage;
        uart_rx_valid = rx_valid_stage;
        uart_tx_ready = tx_ready_stage;
        cycle_cnt     = cyc_stage;
        instr_cnt     = ins_stage;
        // byte 0 is written only at offset 0
        exp_stu  = en && st && a[31] && a[4:2] == 3'd0 && a[1:0] == 2'd0;
        exp_lfu  = en && ld && a[31] && a[4:2] == 3'd1;
        exp_load = '0;
        if (en && ld) begin
            exp_load = a[31] ? mmio_expect(a[4:2]) : dmem_expect(a, w);
        end
        @(negedge clk);
        assert (load_valid === pend_valid)
            else value_error("load_valid", word_t'(load_valid), word_t'(pend_valid));
        if (pend_valid) begin
            assert (load_data === pend_data)
                else value_error("load_data", load_data, pend_data);
        end
        assert (store_to_uart === exp_stu)
            else value_error("store_to_uart", word_t'(store_to_uart), word_t'(exp_stu));
        assert (load_from_uart === exp_lfu)
            else value_error("load_from_uart", word_t'(load_from_uart), word_t'(exp_lfu));
        assert (uart_tx_data === tx_model)
            else value_error("uart_tx_data", word_t'(uart_tx_data), word_t'(tx_model));
        assert (cnt_reset === cnt_model)
            else value_error("cnt_reset", word_t'(cnt_reset), word_t'(cnt_model));
        // model state moves on after the compare
        pend_valid = en && ld;
        pend_data  = exp_load;
        if (en && st && !a[31]) begin
            store_model(a, d, w);
        end
        if (exp_stu) begin
            tx_model = d[7:0];
        end
        if (en && st && a[31] && a[4:2] == 3'd4 && a[1:0] == 2'd0) begin
            cnt_model = d[0];
        end
    endtask

    task automatic idle();
        issue(1'b0, 1'b0, 1'b0, '0, '0, width_word);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            passed++;
            $display("test %-14s passed", name);
        end else begin
            failed++;
            $display("test %-14s failed with %0d mismatches", name, test_errors);
        end
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic reset_test();
        test_errors = 0;
        // check every falling edge while reset is held and the one after
        do begin
            @(negedge clk);
            assert ({uart_tx_data, cnt_reset, load_from_uart, store_to_uart,
                     load_valid} === '0)
                else value_error("reset outputs", word_t'({uart_tx_data, cnt_reset,
                                 load_from_uart, store_to_uart, load_valid}), '0);
        end while (rst);
        finish_test("reset state");
    endtask

    task automatic word_test();
        word_t addrs [16];
        test_errors = 0;
        for (int i = 0; i < 16; i++) begin
            addrs[i] = word_t'($urandom_range(63, 0)) << 2;
            issue(1'b1, 1'b0, 1'b1, addrs[i], $urandom, width_word);
        end
        // back-to-back loads with a gap after every fourth
        for (int i = 0; i < 16; i++) begin
            issue(1'b1, 1'b1, 1'b0, addrs[i], '0, width_word);
            if (i % 4 == 3) begin
                idle();
            end
        end
        finish_test("word access");
    endtask

    task automatic sub_word_test();
        word_t      base;
        word_t      d;
        mem_width_e widths [5];
        test_errors = 0;
        widths = '{width_byte, width_half, width_word, width_byte_u, width_half_u};
        base   = word_t'($urandom_range(63, 0)) << 2;
        issue(1'b1, 1'b0, 1'b1, base, $urandom, width_word);
        for (int off = 0; off < 4; off += 2) begin
            issue(1'b1, 1'b0, 1'b1, base + off, $urandom, width_half);
        end
        // upper half gets negative bytes and the lower half positive
        for (int off = 0; off < 4; off++) begin
            d    = $urandom;
            d[7] = off[1];
            issue(1'b1, 1'b0, 1'b1, base + off, d, width_byte);
        end
        for (int i = 0; i < 5; i++) begin
            for (int off = 0; off < 4; off += access_bytes(widths[i])) begin
                issue(1'b1, 1'b1, 1'b0, base + off, '0, widths[i]);
            end
        end
        idle();
        finish_test("sub-word");
    endtask

    task automatic mmio_store_test();
        test_errors = 0;
        // dmem words whose low bits alias mmio index 0 and 4
        issue(1'b1, 1'b0, 1'b1, 32'h0000_0000, 32'h1234_5678, width_word);
        issue(1'b1, 1'b0, 1'b1, 32'h0000_0010, 32'h9abc_def0, width_word);
        issue(1'b1, 1'b0, 1'b1, 32'h8000_0000, $urandom, width_word);
        idle();
        // byte 1 only so the tx byte stays
        issue(1'b1, 1'b0, 1'b1, 32'h8000_0001, $urandom, width_byte);
        issue(1'b1, 1'b0, 1'b1, 32'h8000_0010, 32'h0000_0001, width_word);
        idle();
        issue(1'b1, 1'b0, 1'b1, 32'h8000_0010, 32'h0000_0002, width_byte);
        issue(1'b1, 1'b1, 1'b0, 32'h0000_0000, '0, width_word);
        issue(1'b1, 1'b1, 1'b0, 32'h0000_0010, '0, width_word);
        idle();
        finish_test("mmio store");
    endtask

    task automatic mmio_load_test();
        test_errors = 0;
        // every index with fresh side inputs each cycle
        for (int idx = 0; idx < 8; idx++) begin
            rx_stage       = 8'($urandom);
            rx_valid_stage = 1'($urandom_range(1, 0));
            tx_ready_stage = 1'($urandom_range(1, 0));
            cyc_stage      = $urandom;
            ins_stage      = $urandom;
            issue(1'b1, 1'b1, 1'b0, 32'h8000_0000 | (word_t'(idx) << 2), '0, width_word);
        end
        idle();
        finish_test("mmio load");
    endtask

    // --------------------
    // run control
    // --------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(36867));
        req_en         = 1'b0;
        req_load       = 1'b0;
        req_store      = 1'b0;
        addr           = '0;
        store_data     = '0;
        width          = width_word;
        uart_rx_data   = '0;
        uart_rx_valid  = 1'b0;
        uart_tx_ready  = 1'b0;
        cycle_cnt      = '0;
        instr_cnt      = '0;
        rx_stage       = '0;
        rx_valid_stage = 1'b0;
        tx_ready_stage = 1'b0;
        cyc_stage      = '0;
        ins_stage      = '0;
        pend_valid     = 1'b0;
        pend_data      = '0;
        tx_model       = '0;
        cnt_model      = 1'b0;
        passed         = 0;
        failed         = 0;
        reset_test();
        word_test();
        sub_word_test();
        mmio_store_test();
        mmio_load_test();
        // let the last concurrent checks settle
        idle();
        idle();
        $display("tests passed %0d, failed %0d, checker failures %0d",
                 passed, failed, uut.u_chk.fail_count);
        if (failed == 0 && uut.u_chk.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
dms_pkg.sv
mem_req_if.sv
store_align.sv
dmem.sv
mmio_regs.sv
load_shift_mask.sv
data_mem_space.sv
tb_clk_gen.sv
data_mem_space_chk.sv
data_mem_space_tb.sv

// File: Bender.yml
package:
  name: data_mem_space

export_include_dirs:
  - .

sources:
  - dms_pkg.sv
  - mem_req_if.sv
  - store_align.sv
  - dmem.sv
  - mmio_regs.sv
  - load_shift_mask.sv
  - data_mem_space.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - data_mem_space_chk.sv
      - data_mem_space_tb.sv
